// File: all.f
+incdir+tb
hdl/aesPkg.sv
hdl/expandKey.sv
hdl/aesRound.sv
hdl/aesCore.sv
hdl/aesTop.sv
tb/aesTb.sv

// File: run.sh
#!/bin/sh
# build and run the AES-128 testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module aesTb -o aesSim

status=0
./obj_dir/aesSim > sim.log 2>&1 || status=$?
cat sim.log
[ "$status" -eq 0 ]
grep -qx "TEST PASS" sim.log

// File: tb/aesModel.svh
//////////////////////////////////////////////////////////////////////
// AES-128 encryption reference model, built from GF(2^8) arithmetic
// so that it needs no substitution table
//////////////////////////////////////////////////////////////////////

`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

// product of two field elements modulo x^8 + x^4 + x^3 + x + 1
function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] term;
    acc  = 8'h00;
    term = a;
    for (int i = 0; i < 8; i++)
    begin
        if (b[i])
        begin
            acc = acc ^ term;
        end
        term = {term[6:0], 1'b0} ^ (term[7] ? 8'h1b : 8'h00);
    end
    return acc;
endfunction

// inverse as x^254 by repeated squaring, then the affine map with constant 63
function automatic logic [7:0] sboxByte(input logic [7:0] x);
    logic [7:0] inv;
    logic [7:0] pow;
    inv = 8'h01;
    pow = gfMul(x, x);
    for (int k = 1; k < 8; k++)
    begin
        inv = gfMul(inv, pow);
        pow = gfMul(pow, pow);
    end
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
        ^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

// byte 0 is the leftmost byte of the hex value
function automatic logic [7:0] byteAt(input logic [127:0] v, input int i);
    return v[127 - 8*i -: 8];
endfunction

function automatic logic [127:0] nextRoundKey(input logic [127:0] prev, input logic [7:0] rc);
    logic [31:0]  temp;
    logic [127:0] next;
    temp = {sboxByte(byteAt(prev, 13)) ^ rc, sboxByte(byteAt(prev, 14)),
            sboxByte(byteAt(prev, 15)), sboxByte(byteAt(prev, 12))};
    next[127:96] = prev[127:96] ^ temp;
    next[95:64]  = next[127:96] ^ prev[95:64];
    next[63:32]  = next[95:64] ^ prev[63:32];
    next[31:0]   = next[63:32] ^ prev[31:0];
    return next;
endfunction

function automatic logic [127:0] cipherRound(input logic [127:0] st, input logic [127:0] rk,
                                             input logic last);
    logic [127:0] shifted;
    logic [127:0] mixed;
    logic [7:0]   a0;
    logic [7:0]   a1;
    logic [7:0]   a2;
    logic [7:0]   a3;
    for (int c = 0; c < 4; c++)
    begin
        for (int r = 0; r < 4; r++)
        begin
            shifted[127 - 8*(4*c + r) -: 8] = sboxByte(byteAt(st, 4*((c + r) % 4) + r));
        end
    end
    mixed = shifted;
    if (!last)
    begin
        for (int c = 0; c < 4; c++)
        begin
            a0 = byteAt(shifted, 4*c);
            a1 = byteAt(shifted, 4*c + 1);
            a2 = byteAt(shifted, 4*c + 2);
            a3 = byteAt(shifted, 4*c + 3);
            mixed[127 - 8*(4*c) -: 8]     = gfMul(8'h02, a0) ^ gfMul(8'h03, a1) ^ a2 ^ a3;
            mixed[127 - 8*(4*c + 1) -: 8] = a0 ^ gfMul(8'h02, a1) ^ gfMul(8'h03, a2) ^ a3;
            mixed[127 - 8*(4*c + 2) -: 8] = a0 ^ a1 ^ gfMul(8'h02, a2) ^ gfMul(8'h03, a3);
            mixed[127 - 8*(4*c + 3) -: 8] = gfMul(8'h03, a0) ^ a1 ^ a2 ^ gfMul(8'h02, a3);
        end
    end
    return mixed ^ rk;
endfunction

function automatic logic [127:0] aesEncrypt(input logic [127:0] key, input logic [127:0] pt);
    logic [127:0] st;
    logic [127:0] rk;
    logic [7:0]   rc;
    st = pt ^ key;
    rk = key;
    rc = 8'h01;
    for (int round = 1; round <= 10; round++)
    begin
        rk = nextRoundKey(rk, rc);
        st = cipherRound(st, rk, round == 10);
        rc = gfMul(rc, 8'h02);
    end
    return st;
endfunction

`endif

// File: tb/aesTb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the AES-128 engine: known answer, random blocks,
// response stalls and handshake timing against a reference model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module aesTb;

    import aesPkg::*;

    localparam int RESET_CYCLES   = 5;
    localparam int DRIVE_DELAY    = 1;
    localparam int NUM_RANDOM     = 40;
    localparam int RSP_LATENCY    = 12;
    // also used as a mask, so it must stay one less than a power of two
    localparam int MAX_STALL      = 7;
    // the request slot, the latency, the longest stall and the transfer cycle
    localparam int MAX_REQ_CYCLES = RSP_LATENCY + MAX_STALL + 2;
    localparam int TIMEOUT_CYCLES = 2 * ((NUM_RANDOM + 1) * MAX_REQ_CYCLES + RESET_CYCLES);

    // FIPS-197 appendix C.1 vector
    localparam logic [127:0] KAT_KEY = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [127:0] KAT_PT  = 128'h00112233445566778899aabbccddeeff;
    localparam logic [127:0] KAT_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic    clk;
    logic    rst;
    logic    reqValid;
    logic    reqReady;
    aesReq_t reqData;
    logic    rspValid;
    logic    rspReady;
    block_t  rspData;

    integer  seed = 32'hfb09;
    int      errorCount = 0;
    int      checkCount = 0;
    int      cycleCount = 0;
    block_t  expQueue [$];

    `include "aesModel.svh"

    aesTop u_aesTop
    (
        .clk      (clk),
        .rst      (rst),
        .reqValid (reqValid),
        .reqReady (reqReady),
        .reqData  (reqData),
        .rspValid (rspValid),
        .rspReady (rspReady),
        .rspData  (rspData)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the test sequence did not finish within %0d cycles", cycleCount);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [127:0] actual,
                              input logic [127:0] expected);
        checkCount++;
        if (actual !== expected)
        begin
            $display("Error: %s is %h, expected %h", name, actual, expected);
            errorCount++;
        end
    endtask

    // inputs change just after the rising edge, outputs are sampled on the falling one
    task automatic driveSlot();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic checkIdle();
        checkValue("reqReady", 128'(reqReady), 128'(1'b1));
        checkValue("rspValid", 128'(rspValid), 128'(1'b0));
    endtask

    task automatic resetDut();
        for (int i = 0; i < RESET_CYCLES; i++)
        begin
            driveSlot();
            if (i == RESET_CYCLES - 1)
            begin
                rst = 1'b0;
            end
            @(negedge clk);
            checkIdle();
        end
        @(negedge clk);
        checkIdle();
    endtask

    // one full encryption with the response held off for stall cycles
    task automatic runRequest(input logic [127:0] key, input logic [127:0] pt,
                              input logic [127:0] expected, input int stall);
        int     cycles;
        block_t firstData;
        block_t expectedRsp;
        driveSlot();
        reqValid          = 1'b1;
        reqData.key       = key;
        reqData.plaintext = pt;
        @(negedge clk);
        while (!reqReady)
        begin
            @(negedge clk);
        end
        expQueue.push_back(expected);

        // the accepting cycle counts as cycle 0
        driveSlot();
        reqValid = 1'b0;
        rspReady = (stall == 0);
        @(negedge clk);
        cycles = 1;
        checkValue("reqReady", 128'(reqReady), 128'(1'b0));
        while (!rspValid)
        begin
            @(negedge clk);
            cycles++;
            checkValue("reqReady", 128'(reqReady), 128'(1'b0));
        end
        checkValue("rspLatency", 128'(cycles), 128'(RSP_LATENCY));
        firstData = rspData;

        if (stall > 0)
        begin
            for (int s = 0; s < stall; s++)
            begin
                driveSlot();
                if (s == stall - 1)
                begin
                    rspReady = 1'b1;
                end
                @(negedge clk);
                checkValue("rspValid", 128'(rspValid), 128'(1'b1));
                checkValue("reqReady", 128'(reqReady), 128'(1'b0));
                checkValue("rspDataHeld", rspData, firstData);
            end
        end

        // rspValid and rspReady are both high here, so the transfer is on the next edge
        expectedRsp = expQueue.pop_front();
        checkValue("rspData", rspData, expectedRsp);
        driveSlot();
        rspReady = 1'b0;
        @(negedge clk);
        checkIdle();
    endtask

    initial
    begin
        logic [127:0] key;
        logic [127:0] pt;
        int           draw;
        int           stall;
        rst      = 1'b1;
        reqValid = 1'b0;
        reqData  = '0;
        rspReady = 1'b0;

        resetDut();

        checkValue("modelKnownAnswer", aesEncrypt(KAT_KEY, KAT_PT), KAT_CT);
        runRequest(KAT_KEY, KAT_PT, KAT_CT, 0);

        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            key   = {$random(seed), $random(seed), $random(seed), $random(seed)};
            pt    = {$random(seed), $random(seed), $random(seed), $random(seed)};
            draw  = $random(seed);
            stall = draw & MAX_STALL;
            runRequest(key, pt, aesEncrypt(key, pt), stall);
        end

        $display("Finished: %0d errors in %0d checks", errorCount, checkCount);
        if (errorCount == 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: hdl/aesTop.sv
//////////////////////////////////////////////////////////////////////
// AES-128 encryption engine, the iterative core with its key expander
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module aesTop
(
    input  logic            clk,
    input  logic            rst,
    input  logic            reqValid,
    output logic            reqReady,
    input  aesPkg::aesReq_t reqData,
    output logic            rspValid,
    input  logic            rspReady,
    output aesPkg::block_t  rspData
);

    import aesPkg::*;

    key_t       cipherKey;
    roundKeys_t roundKeys;

    aesCore u_aesCore
    (
        .clk       (clk),
        .rst       (rst),
        .reqValid  (reqValid),
        .reqReady  (reqReady),
        .reqData   (reqData),
        .rspValid  (rspValid),
        .rspReady  (rspReady),
        .rspData   (rspData),
        .cipherKey (cipherKey),
        .roundKeys (roundKeys)
    );

    // the schedule is combinational from the stored key
    expandKey u_expandKey
    (
        .key       (cipherKey),
        .roundKeys (roundKeys)
    );

endmodule

// File: hdl/aesCore.sv
//////////////////////////////////////////////////////////////////////
// iterative AES-128 encryption controller, one round per clock with
// valid/ready handshakes on the request and response sides
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module aesCore
(
    input  logic               clk,
    input  logic               rst,
    input  logic               reqValid,
    output logic               reqReady,
    input  aesPkg::aesReq_t    reqData,
    output logic               rspValid,
    input  logic               rspReady,
    output aesPkg::block_t     rspData,
    output aesPkg::key_t       cipherKey,
    input  aesPkg::roundKeys_t roundKeys
);

    import aesPkg::*;

    localparam int ROUND_BITS = $clog2(NUM_ROUNDS + 1);

    typedef enum logic [1:0]
    {
        IDLE,
        WHITEN,
        ROUND,
        DONE
    } coreState_t;

    coreState_t            state;
    logic [ROUND_BITS-1:0] roundCnt;
    logic                  finalRound;
    key_t                  keyReg;
    block_t                stateReg;
    block_t                roundOut;

    // one edge loads the block, one whitens it and ten run the rounds
    // so rspValid is registered high on the 11th edge after acceptance
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= IDLE;
            roundCnt <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (reqValid)
                    begin
                        state <= WHITEN;
                    end
                end
                WHITEN:
                begin
                    state    <= ROUND;
                    roundCnt <= ROUND_BITS'(1);
                end
                ROUND:
                begin
                    if (finalRound)
                    begin
                        state <= DONE;
                    end
                    else
                    begin
                        roundCnt <= roundCnt + 1'b1;
                    end
                end
                default:
                begin
                    if (rspReady)
                    begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        case (state)
            IDLE:
            begin
                if (reqValid)
                begin
                    keyReg   <= reqData.key;
                    stateReg <= reqData.plaintext;
                end
            end
            WHITEN:
            begin
                stateReg <= stateReg ^ roundKeys[0];
            end
            ROUND:
            begin
                stateReg <= roundOut;
            end
            default:
            begin
                stateReg <= stateReg;
            end
        endcase
    end

    assign finalRound = (roundCnt == ROUND_BITS'(NUM_ROUNDS));

    aesRound u_aesRound
    (
        .stateIn    (stateReg),
        .roundKey   (roundKeys[roundCnt]),
        .finalRound (finalRound),
        .stateOut   (roundOut)
    );

    assign reqReady  = (state == IDLE);
    assign rspValid  = (state == DONE);
    assign rspData   = stateReg;
    assign cipherKey = keyReg;

    a_rspHeld: assert property (@(posedge clk) disable iff (rst)
        rspValid && !rspReady |=> rspValid && $stable(rspData));

    a_roundInRange: assert property (@(posedge clk) disable iff (rst)
        state == ROUND |-> roundCnt >= ROUND_BITS'(1) && roundCnt <= ROUND_BITS'(NUM_ROUNDS));

endmodule

// File: hdl/aesRound.sv
//////////////////////////////////////////////////////////////////////
// one AES cipher round: SubBytes, ShiftRows, MixColumns unless this
// is the final round, then AddRoundKey
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module aesRound
(
    input  aesPkg::block_t stateIn,
    input  aesPkg::block_t roundKey,
    input  logic           finalRound,
    output aesPkg::block_t stateOut
);

    import aesPkg::*;

    localparam int NUM_COLS = 4;
    localparam int NUM_ROWS = BLOCK_BYTES / NUM_COLS;

    typedef byte_t [0:NUM_ROWS-1] column_t;

    block_t subbed;
    block_t shifted;
    block_t mixed;

    always_comb
    begin
        for (int i = 0; i < BLOCK_BYTES; i++)
        begin
            subbed[i] = subByte(stateIn[i]);
        end
    end

    // state byte (row r, column c) sits at index 4*c + r
    // row r rotates left by r positions
    always_comb
    begin
        for (int c = 0; c < NUM_COLS; c++)
        begin
            for (int r = 0; r < NUM_ROWS; r++)
            begin
                shifted[NUM_ROWS*c + r] = subbed[NUM_ROWS*((c + r) % NUM_COLS) + r];
            end
        end
    end

    always_comb
    begin
        column_t col;
        column_t mixedCol;
        for (int c = 0; c < NUM_COLS; c++)
        begin
            for (int r = 0; r < NUM_ROWS; r++)
            begin
                col[r] = shifted[NUM_ROWS*c + r];
            end
            mixedCol = mixColumn(col);
            for (int r = 0; r < NUM_ROWS; r++)
            begin
                mixed[NUM_ROWS*c + r] = mixedCol[r];
            end
        end
    end

    assign stateOut = (finalRound ? shifted : mixed) ^ roundKey;

    // multiply the column by the fixed polynomial {03}x^3 + {01}x^2 + {01}x + {02}
    // and a factor of 3 is xtime(a) ^ a
    function automatic column_t mixColumn(input column_t a);
        column_t b;
        b[0] = xtime(a[0]) ^ xtime(a[1]) ^ a[1] ^ a[2] ^ a[3];
        b[1] = a[0] ^ xtime(a[1]) ^ xtime(a[2]) ^ a[2] ^ a[3];
        b[2] = a[0] ^ a[1] ^ xtime(a[2]) ^ xtime(a[3]) ^ a[3];
        b[3] = xtime(a[0]) ^ a[0] ^ a[1] ^ a[2] ^ xtime(a[3]);
        return b;
    endfunction

endmodule

// File: hdl/expandKey.sv
//////////////////////////////////////////////////////////////////////
// AES-128 key schedule, expands one cipher key into all round keys
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module expandKey
(
    input  aesPkg::key_t       key,
    output aesPkg::roundKeys_t roundKeys
);

    import aesPkg::*;

    localparam int WORD_BYTES = 4;
    localparam int KEY_WORDS  = KEY_BYTES / WORD_BYTES;

    typedef byte_t [0:WORD_BYTES-1] keyWord_t;
    typedef keyWord_t [0:KEY_WORDS-1] keyWords_t;

    // the whole chain is unrolled, each round key only depends on the one before it
    always_comb
    begin
        keyWords_t prevKey;
        prevKey      = key;
        roundKeys[0] = key;
        for (int r = 1; r <= NUM_ROUNDS; r++)
        begin
            prevKey      = nextKey(r, prevKey);
            roundKeys[r] = prevKey;
        end
    end

    // round key and key block are both 128 bits wide, so no realignment is needed
    function automatic keyWords_t nextKey(input int round, input keyWords_t prevKey);
        keyWords_t newKey;
        newKey[0] = prevKey[0] ^ addRcon(round, subWord(rotWord(prevKey[KEY_WORDS-1])));
        for (int i = 1; i < KEY_WORDS; i++)
        begin
            newKey[i] = newKey[i-1] ^ prevKey[i];
        end
        return newKey;
    endfunction

    // the constant only touches the leading byte of the word
    function automatic keyWord_t addRcon(input int round, input keyWord_t w);
        keyWord_t result;
        result    = w;
        result[0] = w[0] ^ RCON[round-1];
        return result;
    endfunction

    function automatic keyWord_t subWord(input keyWord_t w);
        keyWord_t result;
        for (int i = 0; i < WORD_BYTES; i++)
        begin
            result[i] = subByte(w[i]);
        end
        return result;
    endfunction

    function automatic keyWord_t rotWord(input keyWord_t w);
        return {w[1:WORD_BYTES-1], w[0]};
    endfunction

endmodule

// File: hdl/aesPkg.sv
//////////////////////////////////////////////////////////////////////
// AES-128 shared definitions: data types, S-box, round constants
// and the byte helpers used by the key schedule and the cipher round
//////////////////////////////////////////////////////////////////////

package aesPkg;

    // key length is fixed to 128 bits, so key and state have the same size
    localparam int KEY_BITS    = 128;
    localparam int KEY_BYTES   = KEY_BITS / 8;
    localparam int BLOCK_BYTES = 16;
    localparam int NUM_ROUNDS  = 10;

    typedef logic [7:0] byte_t;

    // byte 0 is the most significant byte, so a hex literal reads in FIPS-197 order
    typedef byte_t [0:BLOCK_BYTES-1] block_t;
    typedef byte_t [0:KEY_BYTES-1]   key_t;

    // entry 0 is the cipher key itself, entry NUM_ROUNDS is the last round key
    typedef block_t [0:NUM_ROUNDS] roundKeys_t;

    typedef struct packed
    {
        key_t   key;
        block_t plaintext;
    } aesReq_t;

    // forward substitution table, indexed by the input byte
    localparam byte_t SBOX [256] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    // round constants for key expansion rounds 1 to 10, stored from index 0
    localparam byte_t RCON [NUM_ROUNDS] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    function automatic byte_t subByte(input byte_t b);
        return SBOX[b];
    endfunction

    // multiply by x in GF(2^8), reducing by the AES polynomial when bit 7 falls out
    function automatic byte_t xtime(input byte_t b);
        byte_t shifted;
        shifted = {b[6:0], 1'b0};
        if (b[7])
        begin
            shifted = shifted ^ 8'h1b;
        end
        return shifted;
    endfunction

endpackage
